/* sources.f */
+incdir+design
design/motor_pkg.sv
design/rate_command_latch.sv
design/motor_mixer.sv
design/motor_pwm.sv
design/motor_output_top.sv
tb/tb_motor_output_top.sv

/* Makefile */
BIN = obj_dir/Vtb_motor_output_top
SOURCES = design/motor_defs.svh design/motor_pkg.sv design/rate_command_latch.sv \
          design/motor_mixer.sv design/motor_pwm.sv design/motor_output_top.sv \
          tb/tb_motor_output_top.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): sources.f $(SOURCES)
	verilator --binary --timing -f sources.f --top-module tb_motor_output_top

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tb/tb_motor_output_top.sv */
// Testbench for the motor output path with reference mixer, compare tasks, checker and watchdog
`timescale 1ns/1ns
`include "motor_defs.svh"

module tb_motor_output_top;

  localparam int mix_iterations    = 200;
  localparam int cutoff_iterations = 20;
  localparam int clamp_iterations  = 20;
  localparam int pwm_iterations    = 3;
  // Reset and link loss each count as one iteration
  localparam int total_iterations  = 1 + mix_iterations + cutoff_iterations
                                     + clamp_iterations + pwm_iterations + 1;
  localparam int watchdog_cycles   = total_iterations * 600;
  localparam int pwm_period        = 255;
  // The mixer loop has five states, so a result comes every five cycles
  localparam int mix_period        = 5;

  logic                   sys_clk;
  logic                   resetn;
  logic                   rate_strobe;
  motor_pkg::rate_t       yaw_rate;
  motor_pkg::rate_t       roll_rate;
  motor_pkg::rate_t       pitch_rate;
  motor_pkg::rate_t       throttle_rate;
  motor_pkg::motor_rate_t motor_1_rate;
  motor_pkg::motor_rate_t motor_2_rate;
  motor_pkg::motor_rate_t motor_3_rate;
  motor_pkg::motor_rate_t motor_4_rate;
  logic                   mix_done;
  logic                   link_lost;
  logic                   pwm_1;
  logic                   pwm_2;
  logic                   pwm_3;
  logic                   pwm_4;

  // Expected rate sets with one entry per strobe and index 0 for motor 1
  logic [3:0][`MOTOR_RATE_WIDTH-1:0] expected_q [$];
  int   results_checked = 0;
  int   error_count     = 0;
  int   tests_passed    = 0;
  int   tests_failed    = 0;
  int   pwm_high [4];
  logic counting_done;

  motor_output_top i_dut (
    .sys_clk       (sys_clk),
    .resetn        (resetn),
    .rate_strobe   (rate_strobe),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .throttle_rate (throttle_rate),
    .motor_1_rate  (motor_1_rate),
    .motor_2_rate  (motor_2_rate),
    .motor_3_rate  (motor_3_rate),
    .motor_4_rate  (motor_4_rate),
    .mix_done      (mix_done),
    .link_lost     (link_lost),
    .pwm_1         (pwm_1),
    .pwm_2         (pwm_2),
    .pwm_3         (pwm_3),
    .pwm_4         (pwm_4)
  );

  // 100 ns clock period
  initial sys_clk = 1'b0;
  always #50 sys_clk = ~sys_clk;

  function automatic motor_pkg::rate_t random_rate(input int lo, input int hi);
    return motor_pkg::rate_t'(lo + int'($urandom % (hi - lo + 1)));
  endfunction

  // X-frame mix of one command set into four expected motor rates
  function automatic logic [3:0][`MOTOR_RATE_WIDTH-1:0] mix_reference(
    input motor_pkg::rate_t yaw, input motor_pkg::rate_t roll,
    input motor_pkg::rate_t pitch, input motor_pkg::rate_t throttle);
    int y;
    int r;
    int p;
    int t;
    int sum [4];
    logic [3:0][`MOTOR_RATE_WIDTH-1:0] rates;
    // Halving rounds toward minus infinity, like an arithmetic shift
    y = int'(yaw) >>> `YAW_SHIFT;
    r = int'(roll) >>> `ROLL_SHIFT;
    p = int'(pitch) >>> `PITCH_SHIFT;
    t = int'(throttle);
    sum[0] = `MOTOR_1_BIAS + t - y + r + p;
    sum[1] = `MOTOR_2_BIAS + t + y - r + p;
    sum[2] = `MOTOR_3_BIAS + t - y - r - p;
    sum[3] = `MOTOR_4_BIAS + t + y + r - p;
    for (int m = 0; m < 4; m++) begin
      if (t <= `MOTOR_VAL_MIN) begin
        sum[m] = 0;
      end else if (sum[m] < `MOTOR_VAL_MIN) begin
        sum[m] = `MOTOR_VAL_MIN;
      end else if (sum[m] > `MOTOR_VAL_MAX) begin
        sum[m] = `MOTOR_VAL_MAX;
      end
      // The two low bits of the 10-bit value are dropped
      rates[m] = motor_pkg::motor_rate_t'(sum[m] / 4);
    end
    return rates;
  endfunction

  task automatic check_motor_rate(input motor_pkg::motor_rate_t expected,
                                  input motor_pkg::motor_rate_t actual, input int motor_index);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t ns: motor %0d rate is %0d, expected %0d",
               $time, motor_index, actual, expected);
    end
  endtask

  task automatic check_flag(input logic expected, input logic actual, input string name);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_pwm_count(input int high_count, input motor_pkg::motor_rate_t duty,
                                 input int motor_index);
    if (high_count != int'(duty)) begin
      error_count++;
      $display("** Error at %0t ns: pwm_%0d high for %0d cycles, expected %0d",
               $time, motor_index, high_count, duty);
    end
  endtask

  task automatic check_rates_zero();
    check_motor_rate('0, motor_1_rate, 1);
    check_motor_rate('0, motor_2_rate, 2);
    check_motor_rate('0, motor_3_rate, 3);
    check_motor_rate('0, motor_4_rate, 4);
  endtask

  // Sends one strobed command and returns once the checker has compared its result
  task automatic send_command(input motor_pkg::rate_t yaw, input motor_pkg::rate_t roll,
                              input motor_pkg::rate_t pitch, input motor_pkg::rate_t throttle);
    int target;
    target = results_checked + 1;
    expected_q.push_back(mix_reference(yaw, roll, pitch, throttle));
    @(posedge sys_clk);
    yaw_rate      <= yaw;
    roll_rate     <= roll;
    pitch_rate    <= pitch;
    throttle_rate <= throttle;
    rate_strobe   <= 1'b1;
    @(posedge sys_clk);
    rate_strobe   <= 1'b0;
    while (results_checked < target) @(negedge sys_clk);
  endtask

  // Any 255 consecutive cycles hold exactly one PWM period
  task automatic count_pwm_high();
    logic [3:0] lines;
    for (int m = 0; m < 4; m++) pwm_high[m] = 0;
    repeat (pwm_period) begin
      @(negedge sys_clk);
      lines = {pwm_4, pwm_3, pwm_2, pwm_1};
      for (int m = 0; m < 4; m++) begin
        if (lines[m]) pwm_high[m]++;
      end
    end
  endtask

  task automatic run_pwm_case(input motor_pkg::rate_t yaw, input motor_pkg::rate_t roll,
                              input motor_pkg::rate_t pitch, input motor_pkg::rate_t throttle);
    logic [3:0][`MOTOR_RATE_WIDTH-1:0] duty;
    duty = mix_reference(yaw, roll, pitch, throttle);
    counting_done = 1'b0;
    fork
      begin
        // Repeated strobes keep the link timeout from zeroing the rates
        while (!counting_done) send_command(yaw, roll, pitch, throttle);
      end
      begin
        // Two periods are enough for the duty to pass shadow and active
        repeat (2 * pwm_period) @(posedge sys_clk);
        count_pwm_high();
        counting_done = 1'b1;
      end
    join
    for (int m = 0; m < 4; m++) check_pwm_count(pwm_high[m], duty[m], m + 1);
  endtask

  task automatic report_test(input string name, input int iterations, input int errors_before);
    int errors;
    errors = error_count - errors_before;
    if (errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("%s: %0d iterations, %0d errors", name, iterations, errors);
  endtask

  // Compares the second mix_done raised after each strobe edge
  initial begin : compare_results
    logic [3:0][`MOTOR_RATE_WIDTH-1:0] expected;
    logic [3:0][`MOTOR_RATE_WIDTH-1:0] actual;
    int done_seen;
    forever begin
      @(negedge sys_clk);
      if (rate_strobe) begin
        // Skip the latch edge because a pulse raised there came from an older set
        @(posedge sys_clk);
        @(posedge sys_clk);
        done_seen = 0;
        while (done_seen < 2) begin
          @(negedge sys_clk);
          if (mix_done) done_seen++;
        end
        if (expected_q.size() == 0) begin
          error_count++;
          $display("A result arrived at %0t ns with no command waiting for it", $time);
        end else begin
          expected = expected_q.pop_front();
          actual = {motor_4_rate, motor_3_rate, motor_2_rate, motor_1_rate};
          for (int m = 0; m < 4; m++) check_motor_rate(expected[m], actual[m], m + 1);
        end
        results_checked++;
      end
    end
  end

  // After the first pulse, mix_done is high for one cycle out of every five
  initial begin : watch_done_pulse
    int phase;
    phase = -1;
    wait (resetn === 1'b1);
    forever begin
      @(negedge sys_clk);
      if (phase < 0) begin
        if (mix_done) phase = 0;
      end else begin
        phase = (phase + 1) % mix_period;
        check_flag(phase == 0, mix_done, "mix_done");
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge sys_clk);
    $display("The tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : run_tests
    int errors_before;
    motor_pkg::rate_t y;
    motor_pkg::rate_t r;
    motor_pkg::rate_t p;
    motor_pkg::rate_t t;
    void'($urandom(96092));
    resetn        <= 1'b0;
    rate_strobe   <= 1'b0;
    yaw_rate      <= '0;
    roll_rate     <= '0;
    pitch_rate    <= '0;
    throttle_rate <= '0;
    repeat (5) @(posedge sys_clk);
    resetn <= 1'b1;

    // The link times out later in this test because nothing strobes yet
    errors_before = error_count;
    @(negedge sys_clk);
    check_rates_zero();
    check_flag(1'b0, mix_done, "mix_done after reset");
    fork
      count_pwm_high();
      for (int i = 0; i < `RATE_TIMEOUT_CYCLES - 4; i++) begin
        @(negedge sys_clk);
        check_flag(1'b0, link_lost, "link_lost after reset");
      end
    join
    for (int m = 0; m < 4; m++) check_pwm_count(pwm_high[m], '0, m + 1);
    report_test("reset state", 1, errors_before);

    errors_before = error_count;
    for (int i = 0; i < mix_iterations; i++) begin
      y = random_rate(-512, 512);
      r = random_rate(-512, 512);
      p = random_rate(-512, 512);
      t = random_rate(16, 800);
      send_command(y, r, p, t);
    end
    report_test("mixing", mix_iterations, errors_before);

    errors_before = error_count;
    for (int i = 0; i < cutoff_iterations; i++) begin
      y = random_rate(-512, 512);
      r = random_rate(-512, 512);
      p = random_rate(-512, 512);
      t = (i == 0) ? '0 : random_rate(-800, 0);
      send_command(y, r, p, t);
    end
    report_test("throttle cut-off", cutoff_iterations, errors_before);

    // Sums well outside 0..1023 in both directions
    errors_before = error_count;
    for (int i = 0; i < clamp_iterations; i++) begin
      y = random_rate(-4000, 4000);
      r = random_rate(-4000, 4000);
      p = random_rate(-4000, 4000);
      t = random_rate(600, 2000);
      send_command(y, r, p, t);
    end
    report_test("clamping", clamp_iterations, errors_before);

    // Mid duty, full scale, and one motor clamped to zero
    errors_before = error_count;
    run_pwm_case(16'sd40, -16'sd24, 16'sd64, 16'sd400);
    run_pwm_case(16'sd0, 16'sd0, 16'sd0, 16'sd1500);
    run_pwm_case(16'sd0, 16'sd400, 16'sd400, 16'sd200);
    report_test("pwm duty", pwm_iterations, errors_before);

    errors_before = error_count;
    repeat (`RATE_TIMEOUT_CYCLES + 20) @(posedge sys_clk);
    @(negedge sys_clk);
    check_flag(1'b1, link_lost, "link_lost after silence");
    check_rates_zero();
    y = random_rate(-512, 512);
    r = random_rate(-512, 512);
    p = random_rate(-512, 512);
    t = random_rate(16, 800);
    send_command(y, r, p, t);
    check_flag(1'b0, link_lost, "link_lost after new strobe");
    report_test("link loss", 1, errors_before);

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* design/motor_output_top.sv */
// Motor output path top level joining command latch, mixer and PWM block
`timescale 1ns/1ns

module motor_output_top (
  input  logic                    sys_clk,
  input  logic                    resetn,
  input  logic                    rate_strobe,
  input  motor_pkg::rate_t        yaw_rate,
  input  motor_pkg::rate_t        roll_rate,
  input  motor_pkg::rate_t        pitch_rate,
  input  motor_pkg::rate_t        throttle_rate,
  output motor_pkg::motor_rate_t  motor_1_rate,
  output motor_pkg::motor_rate_t  motor_2_rate,
  output motor_pkg::motor_rate_t  motor_3_rate,
  output motor_pkg::motor_rate_t  motor_4_rate,
  output logic                    mix_done,
  output logic                    link_lost,
  output logic                    pwm_1,
  output logic                    pwm_2,
  output logic                    pwm_3,
  output logic                    pwm_4
);

  // Held command set, stable while the mixer walks through its states
  motor_pkg::rate_t held_yaw;
  motor_pkg::rate_t held_roll;
  motor_pkg::rate_t held_pitch;
  motor_pkg::rate_t held_throttle;

  rate_command_latch i_latch (
    .sys_clk       (sys_clk),
    .resetn        (resetn),
    .rate_strobe   (rate_strobe),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .throttle_rate (throttle_rate),
    .held_yaw      (held_yaw),
    .held_roll     (held_roll),
    .held_pitch    (held_pitch),
    .held_throttle (held_throttle),
    .link_lost     (link_lost)
  );

  motor_mixer i_mixer (
    .sys_clk       (sys_clk),
    .resetn        (resetn),
    .held_yaw      (held_yaw),
    .held_roll     (held_roll),
    .held_pitch    (held_pitch),
    .held_throttle (held_throttle),
    .motor_1_rate  (motor_1_rate),
    .motor_2_rate  (motor_2_rate),
    .motor_3_rate  (motor_3_rate),
    .motor_4_rate  (motor_4_rate),
    .mix_done      (mix_done)
  );

  // Mixer results also leave the top for monitoring
  motor_pwm i_pwm (
    .sys_clk      (sys_clk),
    .resetn       (resetn),
    .motor_1_rate (motor_1_rate),
    .motor_2_rate (motor_2_rate),
    .motor_3_rate (motor_3_rate),
    .motor_4_rate (motor_4_rate),
    .mix_done     (mix_done),
    .pwm_1        (pwm_1),
    .pwm_2        (pwm_2),
    .pwm_3        (pwm_3),
    .pwm_4        (pwm_4)
  );

endmodule

/* design/motor_pwm.sv */
// Four channel PWM with shadow and active duty registers and a shared counter
`timescale 1ns/1ns

module motor_pwm (
  input  logic                    sys_clk,
  input  logic                    resetn,
  input  motor_pkg::motor_rate_t  motor_1_rate,
  input  motor_pkg::motor_rate_t  motor_2_rate,
  input  motor_pkg::motor_rate_t  motor_3_rate,
  input  motor_pkg::motor_rate_t  motor_4_rate,
  input  logic                    mix_done,
  output logic                    pwm_1,
  output logic                    pwm_2,
  output logic                    pwm_3,
  output logic                    pwm_4
);

  // Counter runs 0 to 254, so a full-scale duty of 255 stays high all period
  localparam motor_pkg::motor_rate_t count_max = 8'd254;

  motor_pkg::motor_rate_t pwm_count;
  motor_pkg::motor_rate_t duty_in     [4];
  motor_pkg::motor_rate_t shadow_duty [4];
  motor_pkg::motor_rate_t active_duty [4];

  assign duty_in[0] = motor_1_rate;
  assign duty_in[1] = motor_2_rate;
  assign duty_in[2] = motor_3_rate;
  assign duty_in[3] = motor_4_rate;

  always_ff @(posedge sys_clk or negedge resetn) begin
    if (!resetn) begin
      pwm_count <= '0;
      for (int m = 0; m < 4; m++) begin
        shadow_duty[m] <= '0;
        active_duty[m] <= '0;
      end
    end else begin
      // Shadow follows the mixer, active only moves at the period boundary
      for (int m = 0; m < 4; m++) begin
        if (mix_done) begin
          shadow_duty[m] <= duty_in[m];
        end
        if (pwm_count == count_max) begin
          active_duty[m] <= shadow_duty[m];
        end
      end
      pwm_count <= (pwm_count == count_max) ? '0 : pwm_count + 1'b1;
    end
  end

  // Line is high while the counter is below its duty
  assign pwm_1 = pwm_count < active_duty[0];
  assign pwm_2 = pwm_count < active_duty[1];
  assign pwm_3 = pwm_count < active_duty[2];
  assign pwm_4 = pwm_count < active_duty[3];

endmodule

/* design/motor_mixer.sv */
// Five state X-frame motor mixer with scale, sign, sum, clamp and truncate steps
`timescale 1ns/1ns
`include "motor_defs.svh"

module motor_mixer (
  input  logic                    sys_clk,
  input  logic                    resetn,
  input  motor_pkg::rate_t        held_yaw,
  input  motor_pkg::rate_t        held_roll,
  input  motor_pkg::rate_t        held_pitch,
  input  motor_pkg::rate_t        held_throttle,
  output motor_pkg::motor_rate_t  motor_1_rate,
  output motor_pkg::motor_rate_t  motor_2_rate,
  output motor_pkg::motor_rate_t  motor_3_rate,
  output motor_pkg::motor_rate_t  motor_4_rate,
  output logic                    mix_done
);

  // Sign table for the X frame, bit 0 is motor 1
  // A set bit means the scaled axis is subtracted for that motor
  localparam logic [3:0] yaw_negate   = 4'b0101;
  localparam logic [3:0] roll_negate  = 4'b0110;
  localparam logic [3:0] pitch_negate = 4'b1100;

  localparam motor_pkg::rate_t motor_bias [4] = '{
    motor_pkg::rate_t'(`MOTOR_1_BIAS),
    motor_pkg::rate_t'(`MOTOR_2_BIAS),
    motor_pkg::rate_t'(`MOTOR_3_BIAS),
    motor_pkg::rate_t'(`MOTOR_4_BIAS)
  };

  // Bits 9 down to 2 of the clamped 10-bit value form the motor rate
  localparam int trunc_lsb = 2;

  localparam motor_pkg::rate_t val_min = motor_pkg::rate_t'(`MOTOR_VAL_MIN);
  localparam motor_pkg::rate_t val_max = motor_pkg::rate_t'(`MOTOR_VAL_MAX);

  motor_pkg::mixer_state_t state;
  logic                    rates_loaded;

  motor_pkg::rate_t yaw_scale;
  motor_pkg::rate_t roll_scale;
  motor_pkg::rate_t pitch_scale;
  motor_pkg::rate_t throttle_q;
  motor_pkg::rate_t yaw_term   [4];
  motor_pkg::rate_t roll_term  [4];
  motor_pkg::rate_t pitch_term [4];
  motor_pkg::rate_t motor_sum  [4];
  motor_pkg::rate_t motor_clamp [4];

  // Signed saturation of one motor sum into the MIN..MAX window
  function automatic motor_pkg::rate_t clamp_sum(input motor_pkg::rate_t sum);
    if (sum < val_min) begin
      return val_min;
    end else if (sum > val_max) begin
      return val_max;
    end
    return sum;
  endfunction

  // Datapath registers, each stage written one state before it is read
  always_ff @(posedge sys_clk) begin
    case (state)
      motor_pkg::scale_rates: begin
        // Throttle is common to all motors and is not scaled
        yaw_scale   <= held_yaw >>> `YAW_SHIFT;
        roll_scale  <= held_roll >>> `ROLL_SHIFT;
        pitch_scale <= held_pitch >>> `PITCH_SHIFT;
      end
      motor_pkg::convert_rates: begin
        // Throttle is sampled here, one cycle after the other axes
        throttle_q <= held_throttle;
        for (int m = 0; m < 4; m++) begin
          yaw_term[m]   <= yaw_negate[m] ? -yaw_scale : yaw_scale;
          roll_term[m]  <= roll_negate[m] ? -roll_scale : roll_scale;
          pitch_term[m] <= pitch_negate[m] ? -pitch_scale : pitch_scale;
        end
      end
      motor_pkg::rate_calc: begin
        for (int m = 0; m < 4; m++) begin
          motor_sum[m] <= motor_bias[m] + throttle_q + yaw_term[m] + roll_term[m]
                          + pitch_term[m];
        end
      end
      motor_pkg::boundary_check: begin
        // No throttle means no motor spins, whatever the axes ask for
        for (int m = 0; m < 4; m++) begin
          if (throttle_q <= val_min) begin
            motor_clamp[m] <= '0;
          end else begin
            motor_clamp[m] <= clamp_sum(motor_sum[m]);
          end
        end
      end
      default: begin
      end
    endcase
  end

  // State loop, output rates and the done pulse
  always_ff @(posedge sys_clk or negedge resetn) begin
    if (!resetn) begin
      state        <= motor_pkg::scale_rates;
      rates_loaded <= 1'b0;
      mix_done     <= 1'b0;
      motor_1_rate <= '0;
      motor_2_rate <= '0;
      motor_3_rate <= '0;
      motor_4_rate <= '0;
    end else begin
      // The done pulse trails the rate update by one edge
      rates_loaded <= 1'b0;
      mix_done     <= rates_loaded;
      case (state)
        motor_pkg::scale_rates:    state <= motor_pkg::convert_rates;
        motor_pkg::convert_rates:  state <= motor_pkg::rate_calc;
        motor_pkg::rate_calc:      state <= motor_pkg::boundary_check;
        motor_pkg::boundary_check: state <= motor_pkg::send_output;
        motor_pkg::send_output: begin
          motor_1_rate <= motor_clamp[0][trunc_lsb +: `MOTOR_RATE_WIDTH];
          motor_2_rate <= motor_clamp[1][trunc_lsb +: `MOTOR_RATE_WIDTH];
          motor_3_rate <= motor_clamp[2][trunc_lsb +: `MOTOR_RATE_WIDTH];
          motor_4_rate <= motor_clamp[3][trunc_lsb +: `MOTOR_RATE_WIDTH];
          rates_loaded <= 1'b1;
          state        <= motor_pkg::scale_rates;
        end
        // Unused encodings fall back into the loop start
        default:                   state <= motor_pkg::scale_rates;
      endcase
    end
  end

endmodule

/* design/rate_command_latch.sv */
// Command set holding register with link timeout and motor cut-off
`timescale 1ns/1ns
`include "motor_defs.svh"

module rate_command_latch (
  input  logic              sys_clk,
  input  logic              resetn,
  input  logic              rate_strobe,
  input  motor_pkg::rate_t  yaw_rate,
  input  motor_pkg::rate_t  roll_rate,
  input  motor_pkg::rate_t  pitch_rate,
  input  motor_pkg::rate_t  throttle_rate,
  output motor_pkg::rate_t  held_yaw,
  output motor_pkg::rate_t  held_roll,
  output motor_pkg::rate_t  held_pitch,
  output motor_pkg::rate_t  held_throttle,
  output logic              link_lost
);

  // Counter must be able to hold the timeout value itself
  localparam int timeout_width = $clog2(`RATE_TIMEOUT_CYCLES + 1);
  localparam logic [timeout_width-1:0] timeout_limit = timeout_width'(`RATE_TIMEOUT_CYCLES);

  logic [timeout_width-1:0] timeout_count;

  always_ff @(posedge sys_clk or negedge resetn) begin
    if (!resetn) begin
      held_yaw      <= '0;
      held_roll     <= '0;
      held_pitch    <= '0;
      held_throttle <= '0;
      timeout_count <= '0;
      link_lost     <= 1'b0;
    end else if (rate_strobe) begin
      // A strobe always wins, even while the link is flagged as lost
      held_yaw      <= yaw_rate;
      held_roll     <= roll_rate;
      held_pitch    <= pitch_rate;
      held_throttle <= throttle_rate;
      timeout_count <= '0;
      link_lost     <= 1'b0;
    end else if (timeout_count == timeout_limit) begin
      // Silence from the flight controller, so drop every command to zero
      // Zero throttle makes the mixer cut all four motors
      held_yaw      <= '0;
      held_roll     <= '0;
      held_pitch    <= '0;
      held_throttle <= '0;
      link_lost     <= 1'b1;
    end else begin
      timeout_count <= timeout_count + 1'b1;
    end
  end

endmodule

/* design/motor_pkg.sv */
// Rate and motor rate types plus the mixer state enum
`include "motor_defs.svh"

package motor_pkg;

  // Signed Q12.4 attitude command, also used for the mixer sums
  typedef logic signed [`RATE_WIDTH-1:0] rate_t;

  // Unsigned motor rate, fed straight to the PWM duty
  typedef logic [`MOTOR_RATE_WIDTH-1:0] motor_rate_t;

  // Mixer loop, one state per clock, never stalls
  typedef enum logic [2:0] {
    scale_rates,
    convert_rates,
    rate_calc,
    boundary_check,
    send_output
  } mixer_state_t;

endpackage

/* design/motor_defs.svh */
// Width, shift, bias, clamp and link timeout macros for the motor output path
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// Command and internal sum width, Q12.4 signed
`define RATE_WIDTH 16
// Motor rate and PWM duty width
`define MOTOR_RATE_WIDTH 8

// Arithmetic right shifts applied to each axis before mixing
`define YAW_SHIFT 1
`define ROLL_SHIFT 1
`define PITCH_SHIFT 1

// Per-motor bias, 1.0 in Q12.4
`define MOTOR_1_BIAS 16
`define MOTOR_2_BIAS 16
`define MOTOR_3_BIAS 16
`define MOTOR_4_BIAS 16

// Clamp window for the mixed sums; MIN is also the throttle cut-off level
`define MOTOR_VAL_MIN 0
`define MOTOR_VAL_MAX 1023

// Cycles without a command strobe before the link is declared lost
`define RATE_TIMEOUT_CYCLES 64

`endif
